/* mulAddCfgDecode.sv */
// configuration register of the tile, loads the mode word on a strobe and splits it into named fields
`timescale 1ns/1ps
`default_nettype none

module mulAddCfgDecode (
	input wire UserCLK, // tile clock
	input wire arstN, // async reset, active low
	input wire cfgLoad, // load strobe
	input wire [mulAddPkg::cfgWidth-1:0] cfgData, // raw mode word
	output mulAddPkg::mulAddCfgT cfg // decoded mode
);

	logic [mulAddPkg::cfgWidth-1:0] cfgReg; // latched mode word

	// take the word on the strobe edge
	// new mode is visible from the next cycle on
	always_ff @(posedge UserCLK or negedge arstN) begin
		if (!arstN) begin
			cfgReg <= '0; // combinational, unsigned, no acc
		end else if (cfgLoad) begin
			cfgReg <= cfgData; // frame load stand-in
		end
	end

	// bit map of the config word
	// the only place that knows bit positions
	always_comb begin
		cfg.regA = cfgReg[0]; // register operand a
		cfg.regB = cfgReg[1]; // register operand b
		cfg.regC = cfgReg[2]; // register operand c
		cfg.accumulate = cfgReg[3]; // acc as addend
		cfg.signExt = cfgReg[4]; // sign-fill product
		cfg.regOut = cfgReg[5]; // registered output
	end

endmodule

`default_nettype wire

/* mulAddExecute.sv */
// operand stage, unsigned 8x8 multiply, product extension, 20-bit add and accumulator of the tile
`timescale 1ns/1ps
`default_nettype none

module mulAddExecute (
	input wire UserCLK, // tile clock
	input wire arstN, // async reset, active low
	input wire mulAddPkg::mulAddCfgT cfg, // decoded mode
	input wire mulAddPkg::mulAddOpsT ops, // live operands
	input wire clr, // clears the accumulator
	output mulAddPkg::mulAddExecT ex // sum, acc and carry
);

	// upper bits filled by the extension
	localparam int extWidth = mulAddPkg::accWidth - mulAddPkg::prodWidth;

	mulAddPkg::mulAddOpsT opsReg; // operands sampled last edge
	mulAddPkg::mulAddOpsT opsUse; // operands in use this cycle

	logic [mulAddPkg::prodWidth-1:0] product; // raw a*b
	logic [mulAddPkg::accWidth-1:0] prodExt; // product widened to acc width
	logic [mulAddPkg::accWidth-1:0] addend; // c or acc
	logic [mulAddPkg::accWidth:0] sumWide; // sum with carry on top
	logic [mulAddPkg::accWidth-1:0] accReg; // accumulator

	// operand registers
	// sampled every edge regardless of mode
	always_ff @(posedge UserCLK or negedge arstN) begin
		if (!arstN) begin
			opsReg <= '0;
		end else begin
			opsReg <= ops; // one cycle behind the inputs
		end
	end

	// per-operand pick between register and live value
	always_comb begin
		opsUse.a = cfg.regA ? opsReg.a : ops.a; // a path
		opsUse.b = cfg.regB ? opsReg.b : ops.b; // b path
		opsUse.c = cfg.regC ? opsReg.c : ops.c; // c path
	end

	// unsigned multiply
	// both factors are opWidth so the context is prodWidth
	assign product = opsUse.a * opsUse.b;

	// sign mode only copies the product msb upward
	// it is not a signed multiply
	always_comb begin
		if (cfg.signExt) begin
			prodExt = {{extWidth{product[mulAddPkg::prodWidth-1]}}, product};
		end else begin
			prodExt = {{extWidth{1'b0}}, product}; // zero fill
		end
	end

	// addend select
	assign addend = cfg.accumulate ? accReg : opsUse.c;

	// one bit wider to catch the carry
	assign sumWide = {1'b0, prodExt} + {1'b0, addend};

	// accumulator
	// clr wins over the load of the sum
	always_ff @(posedge UserCLK or negedge arstN) begin
		if (!arstN) begin
			accReg <= '0;
		end else if (clr) begin
			accReg <= '0; // clear level seen at edge
		end else begin
			accReg <= sumWide[mulAddPkg::accWidth-1:0]; // loads every cycle
		end
	end

	// hand results to the output stage
	always_comb begin
		ex.sum = sumWide[mulAddPkg::accWidth-1:0]; // mod 2^20
		ex.acc = accReg;
		ex.carry = sumWide[mulAddPkg::accWidth]; // bit out of the add
	end

endmodule

`default_nettype wire

/* mulAddPkg.sv */
// shared widths and packed types of the multiply-accumulate tile, compiled ahead of every RTL file
`default_nettype none

package mulAddPkg;

	// operand and datapath widths
	localparam int opWidth = 8; // operands a and b
	localparam int accWidth = 20; // operand c, sum and accumulator
	localparam int prodWidth = 2 * opWidth; // raw unsigned product
	localparam int cfgWidth = 6; // mode bits in the config word

	// decoded mode bits
	// declared msb first so that regA lands on bit 0 of the config word
	typedef struct packed {
		logic regOut; // bit 5 puts the accumulator on q
		logic signExt; // bit 4 extends the product by its top bit
		logic accumulate; // bit 3 adds acc instead of c
		logic regC; // bit 2 takes c from its register
		logic regB; // bit 1 takes b from its register
		logic regA; // bit 0 takes a from its register
	} mulAddCfgT;

	// operand bundle
	// used at the tile input and for the operands in use
	typedef struct packed {
		logic [opWidth-1:0] a; // multiplicand
		logic [opWidth-1:0] b; // multiplier
		logic [accWidth-1:0] c; // addend
	} mulAddOpsT;

	// execute stage results handed to the output stage
	typedef struct packed {
		logic [accWidth-1:0] sum; // product plus addend mod 2^accWidth
		logic [accWidth-1:0] acc; // accumulator register
		logic carry; // carry out of the current add
	} mulAddExecT;

endpackage

`default_nettype wire

/* mulAddResult.sv */
// output stage of the tile, picks live sum or accumulator for q and keeps the sticky carry flag
`timescale 1ns/1ps
`default_nettype none

module mulAddResult (
	input wire UserCLK, // tile clock
	input wire arstN, // async reset, active low
	input wire mulAddPkg::mulAddCfgT cfg, // decoded mode
	input wire mulAddPkg::mulAddExecT ex, // execute results
	input wire clr, // clears the flag
	output logic [mulAddPkg::accWidth-1:0] q, // tile result
	output logic carryFlag // sticky carry out
);

	// output select
	// regOut shows the accumulator, so results land one edge late
	// otherwise the sum goes straight out with no clock in the path
	always_comb begin
		if (cfg.regOut) begin
			q = ex.acc; // registered result
		end else begin
			q = ex.sum; // combinational result
		end
	end

	// sticky carry flag
	// follows the accumulator clear so both drop on the same edge
	// set by any carrying add, whatever the mode
	always_ff @(posedge UserCLK or negedge arstN) begin
		if (!arstN) begin
			carryFlag <= 1'b0;
		end else if (clr) begin
			carryFlag <= 1'b0; // clr has priority
		end else if (ex.carry) begin
			carryFlag <= 1'b1; // add wrapped past 2^20
		end
	end

endmodule

`default_nettype wire

/* mulAddTile.f */
mulAddPkg.sv
mulAddCfgDecode.sv
mulAddExecute.sv
mulAddResult.sv
mulAddTile.sv
mulAddTile_chk.sv
mulAddTile_tb.sv

/* mulAddTile.sv */
// top level of the multiply-accumulate tile, ties config decode, execute and output stage together
`timescale 1ns/1ps
`default_nettype none

module mulAddTile (
	input wire UserCLK, // tile clock
	input wire arstN, // async reset, active low
	input wire cfgLoad, // config load strobe
	input wire [mulAddPkg::cfgWidth-1:0] cfgData, // config word
	input wire mulAddPkg::mulAddOpsT ops, // operands a, b, c
	input wire clr, // clears acc and flag
	output logic [mulAddPkg::accWidth-1:0] q, // result
	output logic carryFlag // sticky carry
);

	mulAddPkg::mulAddCfgT cfg; // decoded mode for execute and result
	mulAddPkg::mulAddExecT ex; // execute to result

	// config register and field map
	mulAddCfgDecode cfgDecode_i (
		.UserCLK (UserCLK),
		.arstN (arstN),
		.cfgLoad (cfgLoad),
		.cfgData (cfgData),
		.cfg (cfg)
	);

	// operand stage, multiply, add, accumulator
	mulAddExecute execute_i (
		.UserCLK (UserCLK),
		.arstN (arstN),
		.cfg (cfg),
		.ops (ops),
		.clr (clr),
		.ex (ex)
	);

	// output mux and carry flag
	mulAddResult result_i (
		.UserCLK (UserCLK),
		.arstN (arstN),
		.cfg (cfg),
		.ex (ex),
		.clr (clr),
		.q (q),
		.carryFlag (carryFlag)
	);

endmodule

`default_nettype wire

/* mulAddTile_chk.sv */
// concurrent assertions on accumulator clear, sticky carry and reset mode, bound into the tile top
`timescale 1ns/1ps
`default_nettype none

module mulAddTile_chk (
	input wire UserCLK, // tile clock
	input wire arstN, // async reset, active low
	input wire clr, // clear level
	input wire carryFlag, // sticky carry
	input wire [mulAddPkg::accWidth-1:0] acc, // accumulator
	input wire mulAddPkg::mulAddCfgT cfg // decoded mode
);

	// clear edge leaves an empty accumulator
	accClear: assert property (@(posedge UserCLK) disable iff (!arstN)
		clr |=> (acc == '0))
		else $error("accumulator not zero after a clr edge");

	// flag drops only on the edge after clr was seen
	flagSticky: assert property (@(posedge UserCLK) disable iff (!arstN)
		$fell(carryFlag) |-> $past(clr))
		else $error("carry flag fell without clr");

	// first edge out of reset still runs the reset mode
	cfgReset: assert property (@(posedge UserCLK)
		$rose(arstN) |-> (cfg == '0))
		else $error("configuration not zero after reset");

endmodule

bind mulAddTile mulAddTile_chk chk_i (
	.UserCLK (UserCLK),
	.arstN (arstN),
	.clr (clr),
	.carryFlag (carryFlag),
	.acc (ex.acc),
	.cfg (cfg)
);

`default_nettype wire

/* mulAddTile_tb.sv */
// directed testbench of the multiply-accumulate tile, run as the simulation top with the file list
`timescale 1ns/1ps
`default_nettype none

module mulAddTile_tb;

	localparam int clkPeriod = 8; // ns
	localparam int fillWidth = mulAddPkg::accWidth - mulAddPkg::prodWidth; // extension bits

	// config word bit positions from bit zero up
	localparam int bitRegA = 0;
	localparam int bitRegB = 1;
	localparam int bitRegC = 2;
	localparam int bitAcc = 3;
	localparam int bitSignExt = 4;
	localparam int bitRegOut = 5;

	// reset plus the cycles each test spends in test order
	localparam int cycleBudget = 11 + 20 + 88 + 21 + 12 + 27 + 43;
	localparam int watchdogCycles = cycleBudget + 200; // generous margin

	logic UserCLK;
	logic arstN;
	logic cfgLoad;
	logic [mulAddPkg::cfgWidth-1:0] cfgData;
	mulAddPkg::mulAddOpsT ops;
	logic clr;
	logic [mulAddPkg::accWidth-1:0] q;
	logic carryFlag;

	// model state built only from what the testbench drove
	logic [mulAddPkg::cfgWidth-1:0] modelCfg; // mode in force
	mulAddPkg::mulAddOpsT modelPrev; // operands at last edge
	logic [mulAddPkg::accWidth-1:0] modelAcc; // expected accumulator
	logic modelFlag; // expected sticky carry

	logic [31:0] lcgState;
	int checkCount;
	int errorCount;
	int testCount;
	int testCheckStart;
	int testErrStart;
	int cycleCount;

	mulAddTile dut_i (
		.UserCLK (UserCLK),
		.arstN (arstN),
		.cfgLoad (cfgLoad),
		.cfgData (cfgData),
		.ops (ops),
		.clr (clr),
		.q (q),
		.carryFlag (carryFlag)
	);

	initial begin
		UserCLK = 1'b0;
		forever #(clkPeriod / 2) UserCLK = ~UserCLK; // 8 ns period
	end

	// ends a run that stalls past the summed test length
	initial begin
		#(watchdogCycles * clkPeriod);
		$display("timeout: tests did not finish within %0d cycles", watchdogCycles);
		$display("STATUS: FAIL");
		$finish;
	end

	function automatic logic [31:0] lcgNext(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223; // numerical recipes constants
	endfunction

	// unsigned a*b widened per sign mode plus c or acc with the carry on top
	function automatic logic [mulAddPkg::accWidth:0] refSum(
		input logic [mulAddPkg::cfgWidth-1:0] mode,
		input logic [mulAddPkg::opWidth-1:0] a,
		input logic [mulAddPkg::opWidth-1:0] b,
		input logic [mulAddPkg::accWidth-1:0] c,
		input logic [mulAddPkg::accWidth-1:0] acc
	);
		logic [mulAddPkg::prodWidth-1:0] prod;
		logic [mulAddPkg::accWidth-1:0] ext;
		logic [mulAddPkg::accWidth-1:0] addend;
		prod = {{mulAddPkg::opWidth{1'b0}}, a} * {{mulAddPkg::opWidth{1'b0}}, b};
		if (mode[bitSignExt]) begin
			ext = {{fillWidth{prod[mulAddPkg::prodWidth-1]}}, prod}; // copy msb up
		end else begin
			ext = {{fillWidth{1'b0}}, prod};
		end
		addend = mode[bitAcc] ? acc : c;
		return {1'b0, ext} + {1'b0, addend};
	endfunction

	function automatic logic [mulAddPkg::cfgWidth-1:0] modeWord(
		input logic rA, input logic rB, input logic rC,
		input logic ac, input logic sx, input logic ro
	);
		logic [mulAddPkg::cfgWidth-1:0] w;
		w = '0;
		w[bitRegA] = rA;
		w[bitRegB] = rB;
		w[bitRegC] = rC;
		w[bitAcc] = ac;
		w[bitSignExt] = sx;
		w[bitRegOut] = ro;
		return w;
	endfunction

	task automatic drawOps(output mulAddPkg::mulAddOpsT o);
		lcgState = lcgNext(lcgState);
		o.a = lcgState[31:24]; // upper bits have the longer period
		o.b = lcgState[23:16];
		lcgState = lcgNext(lcgState);
		o.c = lcgState[31:12];
	endtask

	task automatic compareQ(
		input logic [mulAddPkg::accWidth-1:0] expected,
		input logic [mulAddPkg::accWidth-1:0] actual,
		input string where
	);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("MISMATCH q at %0t (%s): expected %h, got %h", $time, where, expected, actual);
		end
	endtask

	task automatic compareFlag(input logic expected, input logic actual, input string where);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("MISMATCH carryFlag at %0t (%s): expected %h, got %h", $time, where,
				expected, actual);
		end
	endtask

	// drives at the falling edge, checks before the rising edge, then advances the model
	task automatic applyCycle(
		input mulAddPkg::mulAddOpsT o,
		input logic clrV,
		input logic loadV,
		input logic [mulAddPkg::cfgWidth-1:0] word
	);
		mulAddPkg::mulAddOpsT inUse;
		logic [mulAddPkg::accWidth:0] res;
		logic [mulAddPkg::accWidth-1:0] expQ;
		@(negedge UserCLK);
		ops = o;
		clr = clrV;
		cfgLoad = loadV;
		cfgData = word;
		#1; // let the combinational path settle
		cycleCount++;
		inUse.a = modelCfg[bitRegA] ? modelPrev.a : o.a;
		inUse.b = modelCfg[bitRegB] ? modelPrev.b : o.b;
		inUse.c = modelCfg[bitRegC] ? modelPrev.c : o.c;
		res = refSum(modelCfg, inUse.a, inUse.b, inUse.c, modelAcc);
		expQ = modelCfg[bitRegOut] ? modelAcc : res[mulAddPkg::accWidth-1:0];
		compareQ(expQ, q, $sformatf("cycle %0d", cycleCount));
		compareFlag(modelFlag, carryFlag, $sformatf("cycle %0d", cycleCount));
		@(posedge UserCLK);
		modelPrev = o;
		modelAcc = clrV ? '0 : res[mulAddPkg::accWidth-1:0]; // clr wins
		if (clrV) begin
			modelFlag = 1'b0;
		end else if (res[mulAddPkg::accWidth]) begin
			modelFlag = 1'b1; // sticky
		end
		if (loadV) begin
			modelCfg = word; // applies from next cycle
		end
		#1; // outputs stable past the edge
	endtask

	// load a mode with random operands riding along
	task automatic loadMode(input logic [mulAddPkg::cfgWidth-1:0] word);
		mulAddPkg::mulAddOpsT o;
		drawOps(o);
		applyCycle(o, 1'b0, 1'b1, word);
	endtask

	task automatic finishTest(input string name);
		testCount++;
		$display("test %-20s %0d checks, %0d errors", name, checkCount - testCheckStart,
			errorCount - testErrStart);
		testCheckStart = checkCount;
		testErrStart = errorCount;
	endtask

	task automatic defaultsAfterReset();
		mulAddPkg::mulAddOpsT o;
		compareFlag(1'b0, carryFlag, "after reset");
		repeat (20) begin
			drawOps(o);
			applyCycle(o, 1'b0, 1'b0, '0); // reset mode is combinational
		end
		finishTest("reset defaults");
	endtask

	task automatic registeredOperands();
		mulAddPkg::mulAddOpsT o;
		logic [2:0] combo;
		for (int i = 0; i < 8; i++) begin
			combo = i[2:0];
			loadMode(modeWord(combo[0], combo[1], combo[2], 1'b0, 1'b0, 1'b0));
			repeat (10) begin
				drawOps(o);
				applyCycle(o, 1'b0, 1'b0, '0);
			end
		end
		finishTest("registered operands");
	endtask

	task automatic accumulateRegOut();
		mulAddPkg::mulAddOpsT o;
		loadMode(modeWord(1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1));
		drawOps(o);
		applyCycle(o, 1'b1, 1'b0, '0); // start from zero
		repeat (16) begin
			drawOps(o);
			applyCycle(o, 1'b0, 1'b0, '0);
		end
		drawOps(o);
		applyCycle(o, 1'b1, 1'b0, '0);
		compareQ('0, q, "after later clr");
		repeat (2) begin
			drawOps(o);
			applyCycle(o, 1'b0, 1'b0, '0);
		end
		finishTest("accumulate regOut");
	endtask

	task automatic signExtension();
		mulAddPkg::mulAddOpsT o;
		loadMode(modeWord(1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0));
		o.a = 8'hFF;
		o.b = 8'hFF;
		o.c = '0;
		applyCycle(o, 1'b0, 1'b0, '0);
		compareQ(20'hFFE01, q, "255*255 sign fill"); // 0xFE01 has its top bit set
		repeat (4) begin
			drawOps(o);
			o.a = o.a | 8'hC0; // product at least 0x9000
			o.b = o.b | 8'hC0;
			applyCycle(o, 1'b0, 1'b0, '0);
		end
		loadMode('0);
		o.a = 8'hFF;
		o.b = 8'hFF;
		o.c = '0;
		applyCycle(o, 1'b0, 1'b0, '0);
		compareQ(20'h0FE01, q, "255*255 zero fill");
		repeat (4) begin
			drawOps(o);
			o.a = o.a | 8'hC0;
			o.b = o.b | 8'hC0;
			applyCycle(o, 1'b0, 1'b0, '0);
		end
		finishTest("sign extension");
	endtask

	task automatic stickyCarry();
		mulAddPkg::mulAddOpsT maxOps;
		mulAddPkg::mulAddOpsT zeroOps;
		zeroOps = '0;
		maxOps.a = 8'hFF;
		maxOps.b = 8'hFF;
		maxOps.c = 20'hFFFFF;
		loadMode(modeWord(1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0));
		applyCycle(zeroOps, 1'b1, 1'b0, '0);
		repeat (17) begin
			applyCycle(maxOps, 1'b0, 1'b0, '0); // 17 * 65025 passes 2^20
		end
		compareFlag(1'b1, carryFlag, "after accumulator wrap");
		repeat (4) begin
			applyCycle(zeroOps, 1'b0, 1'b0, '0);
		end
		compareFlag(1'b1, carryFlag, "held through quiet edges");
		applyCycle(zeroOps, 1'b1, 1'b0, '0);
		compareFlag(1'b0, carryFlag, "after clr");
		applyCycle(zeroOps, 1'b0, 1'b1, '0); // back to combinational
		compareFlag(1'b0, carryFlag, "after mode load");
		applyCycle(maxOps, 1'b0, 1'b0, '0);
		compareFlag(1'b1, carryFlag, "combinational carry");
		applyCycle(zeroOps, 1'b1, 1'b0, '0);
		finishTest("carry flag");
	endtask

	task automatic midStreamReconfig();
		mulAddPkg::mulAddOpsT o;
		logic [mulAddPkg::cfgWidth-1:0] modeList [0:5];
		logic clrV;
		modeList[0] = modeWord(1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
		modeList[1] = modeWord(1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1);
		modeList[2] = modeWord(1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0);
		modeList[3] = modeWord(1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1);
		modeList[4] = modeWord(1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1);
		modeList[5] = '0;
		drawOps(o);
		applyCycle(o, 1'b1, 1'b0, '0);
		for (int i = 0; i < 6; i++) begin
			drawOps(o);
			applyCycle(o, 1'b0, 1'b1, modeList[i]); // old mode holds this cycle
			repeat (6) begin
				drawOps(o);
				clrV = (lcgState[11:8] == 4'h0); // rare clear
				applyCycle(o, clrV, 1'b0, '0);
			end
		end
		finishTest("reconfiguration");
	endtask

	initial begin
		arstN = 1'b0;
		cfgLoad = 1'b0;
		cfgData = '0;
		ops = '0;
		clr = 1'b0;
		modelCfg = '0;
		modelPrev = '0;
		modelAcc = '0;
		modelFlag = 1'b0;
		lcgState = 32'h553b58e1;
		checkCount = 0;
		errorCount = 0;
		testCount = 0;
		testCheckStart = 0;
		testErrStart = 0;
		cycleCount = 0;
		repeat (10) @(posedge UserCLK);
		@(negedge UserCLK);
		arstN = 1'b1; // release between edges
		defaultsAfterReset();
		registeredOperands();
		accumulateRegOut();
		signExtension();
		stickyCarry();
		midStreamReconfig();
		$display("summary: %0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
		if (errorCount == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# compiles the tile and its testbench with Verilator, runs it and scans the log

set -u
cd "$(dirname "$0")" || exit 1

logFile=sim.log
simBin=mulAddTileSim

verilator --binary --timing --assert \
	--top-module mulAddTile_tb \
	-f mulAddTile.f \
	-o "$simBin"
status=$?
if [ "$status" -ne 0 ]; then
	echo "build failed with status $status"
	exit 1
fi

./obj_dir/"$simBin" > "$logFile" 2>&1
status=$?
cat "$logFile"
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "STATUS: FAIL" "$logFile"; then
	exit 1
fi
exit 0
